//--- verif/lsu_trace.txt
0 2 0 00000000 12345678 12345678 0
2 2 0 80000000 11223344 00000000 0
1 2 0 80000000 00000000 11223344 0
2 0 0 80000001 123456ab 00000000 0
2 1 0 80000002 9876cdef 00000000 0
1 2 0 80000000 00000000 cdefab44 0
2 2 0 a0000010 8899aabb 00000000 0
1 2 0 a0000010 00000000 8899aabb 0
1 0 1 a0000010 00000000 ffffffbb 0
1 0 0 a0000011 00000000 000000aa 0
1 0 1 a0000012 00000000 ffffff99 0
1 0 0 a0000013 00000000 00000088 0
1 1 1 a0000010 00000000 ffffaabb 0
1 1 0 a0000012 00000000 00008899 0
1 0 1 80000000 00000000 00000044 0
1 0 0 80000001 00000000 000000ab 0
1 1 1 80000002 00000000 ffffcdef 0
1 1 0 80000000 00000000 0000ab44 0
2 2 0 80000002 deadbeef 00000000 1
1 1 0 80000001 00000000 00000000 1
2 2 0 10000000 deadbeef 00000000 1
1 2 0 a0000800 00000000 00000000 1
2 1 0 a0000011 0000ffff 00000000 1
1 2 0 80000000 00000000 cdefab44 0
0 0 0 80000001 cafef00d cafef00d 0
1 2 0 a0000010 00000000 8899aabb 0

//--- verilog.f
logic/lsu_pkg.sv
logic/store_align.sv
logic/load_extract.sv
logic/resp_timer.sv
logic/lsu_fsm.sv
logic/axi_sram.sv
logic/lsu_top.sv
verif/lsu_chk.sv
verif/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f verilog.f -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verif/lsu_tb.sv
`timescale 1ns/10ps
module lsu_tb import lsu_pkg::*; ();

    typedef struct packed {
        lsu_req_t    req;
        logic [31:0] exp_rdata;
        logic        exp_fault;
    } test_t;

    logic      clk;
    logic      rst;
    lsu_req_t  req;
    logic      req_valid;
    logic      req_ready;
    lsu_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;

    test_t     tests[$];
    int        n_tests;
    int        n_pass;
    int        n_fail;
    logic      loaded;

    lsu_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    bind lsu_fsm lsu_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready)
    );

    always #5 clk = ~clk;

    // half on odd address, word off a 4 byte boundary
    function automatic logic is_misaligned(input lsu_req_t r);
        if (r.op == OP_NONE) return 1'b0;
        case (r.size)
            SIZE_HALF: return r.addr[0];
            SIZE_WORD: return r.addr[1:0] != 2'b00;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic string kind_name(input lsu_req_t r);
        case (r.op)
            OP_LOAD:  return "load";
            OP_STORE: return "store";
            default:  return "none";
        endcase
    endfunction

    task automatic load_trace();
        int          fd;
        int          cnt;
        logic [31:0] f_op;
        logic [31:0] f_size;
        logic [31:0] f_sext;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_fault;
        test_t       t;
        fd = $fopen("verif/lsu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/lsu_trace.txt");
        end else begin
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h",
                          f_op, f_size, f_sext, f_addr, f_wdata, f_rdata, f_fault);
            while (cnt == 7) begin
                t.req.op    = lsu_op_e'(f_op[1:0]);
                t.req.size  = mem_size_e'(f_size[1:0]);
                t.req.sext  = f_sext[0];
                t.req.addr  = f_addr;
                t.req.wdata = f_wdata;
                t.req.tag   = 5'(tests.size());  // rd follows the line number
                t.exp_rdata = f_rdata;
                t.exp_fault = f_fault[0];
                tests.push_back(t);
                cnt = $fscanf(fd, "%h %h %h %h %h %h %h",
                              f_op, f_size, f_sext, f_addr, f_wdata, f_rdata, f_fault);
            end
            $fclose(fd);
        end
    endtask

    task automatic send_request(input lsu_req_t r, output logic idle_ok);
        @(posedge clk);
        idle_ok   = req_ready && !resp_valid;  // one cycle after the last response
        req       <= r;
        req_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!req_ready);  // accepted on this edge
        req_valid <= 1'b0;
        req       <= '0;
    endtask

    task automatic wait_response(output lsu_resp_t got, output int latency,
                                 output logic stable);
        lsu_resp_t first;
        logic      seen;
        int        cycles;
        seen    = 1'b0;
        stable  = 1'b1;
        cycles  = 0;
        latency = 0;
        first   = '0;
        do begin
            @(posedge clk);
            cycles++;
            if (resp_valid && !seen) begin
                seen    = 1'b1;
                first   = resp;
                latency = cycles;
            end else if (resp_valid && resp != first) begin
                stable = 1'b0;  // moved while stalled
            end
        end while (!(resp_valid && resp_ready));
        got = resp;
    endtask

    task automatic run_test(input int idx);
        test_t     t;
        lsu_resp_t got;
        int        latency;
        logic      stable;
        logic      idle_ok;
        int        bad;
        t   = tests[idx];
        bad = 0;
        send_request(t.req, idle_ok);
        assert (idle_ok) else begin
            $display("CHECK FAILED at %0t: test %0d unit not idle after the last response",
                     $time, idx);
            bad++;
        end
        wait_response(got, latency, stable);
        assert (got.rdata == t.exp_rdata) else begin
            $display("CHECK FAILED at %0t: test %0d rdata %h, expected %h",
                     $time, idx, got.rdata, t.exp_rdata);
            bad++;
        end
        assert (got.fault == t.exp_fault) else begin
            $display("CHECK FAILED at %0t: test %0d fault %b, expected %b",
                     $time, idx, got.fault, t.exp_fault);
            bad++;
        end
        assert (got.tag == t.req.tag && got.addr == t.req.addr) else begin
            $display("CHECK FAILED at %0t: test %0d tag %0d addr %h, expected %0d %h",
                     $time, idx, got.tag, got.addr, t.req.tag, t.req.addr);
            bad++;
        end
        assert (stable) else begin
            $display("CHECK FAILED at %0t: test %0d response changed while held",
                     $time, idx);
            bad++;
        end
        if (t.req.op == OP_NONE || is_misaligned(t.req)) begin
            assert (latency == 1) else begin
                $display("CHECK FAILED at %0t: test %0d took %0d cycles, expected 1",
                         $time, idx, latency);
                bad++;
            end
        end
        if (bad == 0) begin
            n_pass++;
            $display("test %0d %s at %h: ok", idx, kind_name(t.req), t.req.addr);
        end else begin
            n_fail++;
            $display("test %0d %s at %h: FAILED", idx, kind_name(t.req), t.req.addr);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        loaded    = 1'b0;
        load_trace();
        n_tests = tests.size();
        loaded  = 1'b1;
        assert (n_tests > 0) else begin
            $display("the trace file holds no requests");
            n_fail++;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        foreach (tests[i]) run_test(i);
        $display("tests %0d, passed %0d, failed %0d", n_tests, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // write-back stalls about one cycle in four
    initial begin
        resp_ready = 1'b0;
        void'($urandom(40));
        forever begin
            @(posedge clk);
            resp_ready <= rst ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    initial begin
        wait (loaded);
        repeat (10 + n_tests * 100) @(posedge clk);
        $display("run timed out after %0d cycles", 10 + n_tests * 100);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- verif/lsu_chk.sv
`timescale 1ns/10ps
module lsu_chk import lsu_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      req_ready,
    input lsu_resp_t resp,
    input logic      resp_valid,
    input logic      resp_ready,
    input axi_ar_t   ar,
    input logic      arvalid,
    input logic      arready,
    input axi_aw_t   aw,
    input logic      awvalid,
    input logic      awready,
    input logic      wvalid,
    input logic      wready
);
    logic ar_sdram;
    logic aw_sdram;

    assign ar_sdram = (ar.addr[31:11] == SDRAM_BASE[31:11]);  // 2 KiB window
    assign aw_sdram = (aw.addr[31:11] == SDRAM_BASE[31:11]);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("arvalid dropped or ar changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid dropped or aw changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    aw_w_pair: assert property (@(posedge clk) disable iff (rst)
        awvalid == wvalid)
        else $error("awvalid and wvalid not raised together");

    ar_burst: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> ar.burst == (ar_sdram ? BURST_INCR : BURST_FIXED))
        else $error("read burst code does not match the region");

    aw_burst: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> aw.burst == (aw_sdram ? BURST_INCR : BURST_FIXED))
        else $error("write burst code does not match the region");

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response dropped or changed before resp_ready");

    req_blocked: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

endmodule

//--- logic/lsu_top.sv
`timescale 1ns/10ps
module lsu_top import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lsu_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output lsu_resp_t resp,
    output logic      resp_valid,
    input  logic      resp_ready
);
    axi_ar_t ar;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    axi_r_t  r;
    logic    arvalid;
    logic    arready;
    logic    awvalid;
    logic    awready;
    logic    wvalid;
    logic    wready;
    logic    bvalid;
    logic    bready;
    logic    rvalid;
    logic    rready;

    lsu_fsm u_lsu_fsm (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    axi_sram u_axi_sram (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

//--- logic/axi_sram.sv
`timescale 1ns/10ps
module axi_sram import lsu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);
    localparam int WORDS = 2 * REGION_BYTES / 4;
    localparam int IDX_W = $clog2(WORDS);

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RESP} state_e;

    state_e             state;
    logic               wr_q;
    logic               wr_sel;
    logic [31:0]        addr_sel;
    logic               sel_sram;
    logic               sel_sdram;
    logic               mapped;
    logic [IDX_W-1:0]   idx;
    logic               pending;
    logic               accept;
    logic               lat_done;
    logic [TIMER_W-1:0] lat;
    logic [31:0]        mem [WORDS];

    // in idle the write side wins if both are up
    assign wr_sel   = (state == S_IDLE) ? awvalid : wr_q;
    assign addr_sel = wr_sel ? aw.addr : ar.addr;

    assign sel_sram  = in_region(addr_sel, SRAM_BASE);
    assign sel_sdram = in_region(addr_sel, SDRAM_BASE);
    assign mapped    = sel_sram || sel_sdram;
    assign idx       = {sel_sdram, addr_sel[IDX_W:2]};  // sdram in upper half

    // the load cycle already counts as one cycle of waiting
    assign lat     = sel_sdram ? SDRAM_LAT - 1'b1 : SRAM_LAT - 1'b1;
    assign pending = (awvalid && wvalid) || arvalid;

    resp_timer u_resp_timer (
        .clk   (clk),
        .rst   (rst),
        .load  ((state == S_IDLE) && pending),
        .count (lat),
        .done  (lat_done)
    );

    assign arready = (state == S_WAIT) && !wr_q && lat_done;
    assign awready = (state == S_WAIT) && wr_q && lat_done;
    assign wready  = (state == S_WAIT) && wr_q && lat_done;
    assign accept  = wr_q ? (awvalid && awready && wvalid && wready) : (arvalid && arready);
    assign bvalid  = (state == S_RESP) && wr_q;
    assign rvalid  = (state == S_RESP) && !wr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (pending) begin
                    state <= S_WAIT;
                    wr_q  <= awvalid;
                end
                S_WAIT: if (accept) state <= S_RESP;
                S_RESP: if (wr_q ? bready : rready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (wr_q) begin
                b.resp <= mapped ? AXI_OKAY : AXI_SLVERR;
                for (int i = 0; i < 4; i++) begin
                    if (mapped && w.strb[i]) mem[idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end else begin
                r.data <= mapped ? mem[idx] : 32'd0;
                r.resp <= mapped ? AXI_OKAY : AXI_SLVERR;
            end
        end
    end

endmodule

//--- logic/lsu_fsm.sv
`timescale 1ns/10ps
module lsu_fsm import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lsu_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output lsu_resp_t resp,
    output logic      resp_valid,
    input  logic      resp_ready,
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready
);
    typedef enum logic [1:0] {IDLE, ADDR, WAIT, RESP} state_e;

    state_e      state;
    lsu_req_t    req_q;
    logic        misaligned;
    logic        req_mem;
    logic        is_load;
    logic        is_store;
    logic        addr_done;
    logic        bus_done;
    logic [2:0]  axi_size;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic [31:0] load_data;
    axi_ar_t     addr_ch;

    always_comb begin
        case (req.size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = req.addr[0];
            default:   misaligned = |req.addr[1:0];
        endcase
    end

    assign req_mem  = (req.op == OP_LOAD) || (req.op == OP_STORE);
    assign is_load  = (req_q.op == OP_LOAD);
    assign is_store = (req_q.op == OP_STORE);

    store_align u_store_align (
        .addr_lo  (req_q.addr[1:0]),
        .size     (req_q.size),
        .wdata    (req_q.wdata),
        .data     (w_data),
        .strb     (w_strb),
        .axi_size (axi_size)
    );

    load_extract u_load_extract (
        .addr_lo (req_q.addr[1:0]),
        .size    (req_q.size),
        .sext    (req_q.sext),
        .rword   (r.data),
        .rdata   (load_data)
    );

    always_comb begin
        addr_ch.addr  = req_q.addr;
        addr_ch.size  = axi_size;
        addr_ch.burst = in_region(req_q.addr, SDRAM_BASE) ? BURST_INCR : BURST_FIXED;
    end

    assign ar = addr_ch;
    assign aw = addr_ch;
    assign w  = '{data: w_data, strb: w_strb};

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == RESP);
    assign arvalid    = (state == ADDR) && is_load;
    assign awvalid    = (state == ADDR) && is_store;
    assign wvalid     = (state == ADDR) && is_store;  // raised with aw
    assign rready     = (state == WAIT) && is_load;
    assign bready     = (state == WAIT) && is_store;

    assign addr_done = is_load ? (arvalid && arready)
                               : (awvalid && awready && wvalid && wready);
    assign bus_done  = is_load ? (rvalid && rready) : (bvalid && bready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (req_valid) state <= (req_mem && !misaligned) ? ADDR : RESP;
                ADDR: if (addr_done) state <= WAIT;
                WAIT: if (bus_done) state <= RESP;
                RESP: if (resp_ready) state <= IDLE;  // req_ready back next cycle
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q       <= req;
            resp.addr   <= req.addr;
            resp.tag    <= req.tag;
            resp.rdata  <= req_mem ? 32'd0 : req.wdata;  // pass-through result
            resp.fault  <= req_mem && misaligned;
        end else if (bus_done) begin
            resp.rdata  <= (is_load && r.resp == AXI_OKAY) ? load_data : 32'd0;
            resp.fault  <= is_load ? (r.resp != AXI_OKAY) : (b.resp != AXI_OKAY);
        end
    end

endmodule

//--- logic/resp_timer.sv
`timescale 1ns/10ps
module resp_timer import lsu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic [TIMER_W-1:0] count,
    output logic               done
);
    logic [TIMER_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= count;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;  // run down to zero, then hold
        end
    end

    assign done = (cnt == '0);

endmodule

//--- logic/load_extract.sv
`timescale 1ns/10ps
module load_extract import lsu_pkg::*; (
    input  logic [1:0]  addr_lo,
    input  mem_size_e   size,
    input  logic        sext,
    input  logic [31:0] rword,
    output logic [31:0] rdata
);
    logic [31:0] shifted;
    logic        sign;

    assign shifted = rword >> {addr_lo, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                sign  = sext & shifted[7];
                rdata = {{24{sign}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                sign  = sext & shifted[15];
                rdata = {{16{sign}}, shifted[15:0]};
            end
            default: begin
                sign  = 1'b0;  // full word, nothing to extend
                rdata = shifted;
            end
        endcase
    end

endmodule

//--- logic/store_align.sv
`timescale 1ns/10ps
module store_align import lsu_pkg::*; (
    input  logic [1:0]  addr_lo,
    input  mem_size_e   size,
    input  logic [31:0] wdata,
    output logic [31:0] data,
    output logic [3:0]  strb,
    output logic [2:0]  axi_size
);
    logic [3:0] strb_base;

    // move low bytes up to the addressed lane
    assign data = wdata << {addr_lo, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                strb_base = 4'b0001;
                axi_size  = 3'd0;
            end
            SIZE_HALF: begin
                strb_base = 4'b0011;
                axi_size  = 3'd1;
            end
            default: begin
                strb_base = 4'b1111;  // word
                axi_size  = 3'd2;
            end
        endcase
    end

    assign strb = strb_base << addr_lo;

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

    localparam logic [31:0] SRAM_BASE    = 32'h8000_0000;
    localparam logic [31:0] SDRAM_BASE   = 32'hA000_0000;
    localparam logic [31:0] REGION_BYTES = 32'd2048;

    localparam int TIMER_W = 3;
    localparam logic [TIMER_W-1:0] SRAM_LAT  = 3'd1;  // cycles before acceptance
    localparam logic [TIMER_W-1:0] SDRAM_LAT = 3'd4;

    localparam logic [1:0] AXI_OKAY    = 2'b00;
    localparam logic [1:0] AXI_SLVERR  = 2'b10;
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef struct packed {
        lsu_op_e     op;
        mem_size_e   size;
        logic        sext;   // sign extend on load
        logic [31:0] addr;
        logic [31:0] wdata;  // store data or alu result
        logic [4:0]  tag;    // rd
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [31:0] addr;
        logic        fault;
        logic [4:0]  tag;
    } lsu_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;  // same layout as ar

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    function automatic logic in_region(input logic [31:0] addr, input logic [31:0] base);
        return (addr >= base) && ((addr - base) < REGION_BYTES);
    endfunction

endpackage
